/* sim.f */
logic/decodePkg.sv
logic/decodeRp.sv
logic/decodeRegs.sv
logic/decodeClass.sv
logic/decodeStage.sv
dv/decodeStage_props.sv
dv/decodeStageTb.sv

/* Makefile */
# Verilator build and run of the decode stage testbench

SIM = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = decodeStageTb
FILELIST = sim.f

OBJDIR = obj_dir
BIN = $(OBJDIR)/V$(TOP)
LOG = sim.log
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* dv/decodeStageTb.sv */
// Testbench for the decode stage
// Stimulus table with expected specifiers, immediate and class
// Fetch side driver, issue side collector with random back-pressure
// Compare tasks for specifiers, immediates and classes

`timescale 1ns/10ps

module decodeStageTb;

	logic clk;
	logic rstN;
	logic inReq;
	decodePkg::instruction_t instr;
	logic inAck;
	logic outReq;
	decodePkg::regspec_t Rp;
	decodePkg::regspec_t Rt;
	decodePkg::regspec_t Ra;
	decodePkg::regspec_t Rb;
	logic [decodePkg::dataWidth-1:0] imm;
	decodePkg::instrClass_t cls;
	logic outAck;

	// Stimulus table with one entry per instruction in issue order
	string tName[$];
	decodePkg::instruction_t tInstr[$];
	decodePkg::regspec_t tRp[$];
	decodePkg::regspec_t tRt[$];
	decodePkg::regspec_t tRa[$];
	decodePkg::regspec_t tRb[$];
	logic [31:0] tImm[$];
	decodePkg::instrClass_t tCls[$];

	logic [31:0] lcgState;
	int waitLimit = 400;

	decodeStage DUT
	(
		.clk(clk),
		.rstN(rstN),
		.inReq(inReq),
		.instr(instr),
		.inAck(inAck),
		.outReq(outReq),
		.Rp(Rp),
		.Rt(Rt),
		.Ra(Ra),
		.Rb(Rb),
		.imm(imm),
		.cls(cls),
		.outAck(outAck)
	);

	initial
		clk = 1'b0;
	always
		#10 clk = ~clk;

	// ==============================
	// Helpers and compare tasks
	// ==============================

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic failNow(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkReg(input string name, input string field,
		input decodePkg::regspec_t exp, input decodePkg::regspec_t act);
		if (act !== exp)
			failNow($sformatf("error %s %s: expected %0d, actual %0d", name, field, exp, act));
	endtask

	task automatic checkImm(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			failNow($sformatf("error %s imm: expected %h, actual %h", name, exp, act));
	endtask

	task automatic checkClass(input string name, input decodePkg::instrClass_t exp,
		input decodePkg::instrClass_t act);
		if (act !== exp)
			failNow($sformatf("error %s cls: expected %s, actual %s (%0d)", name, exp.name(),
				act.name(), act));
	endtask

	// R2 format with the predicate in bits 36 to 34 and the function in 31 to 25
	function automatic decodePkg::instruction_t encR2(input logic [6:0] fn,
		input logic [2:0] pred, input decodePkg::regspec_t rt, input decodePkg::regspec_t ra,
		input decodePkg::regspec_t rb);
		decodePkg::instruction_t w;
		w = '0;
		w[6:0] = decodePkg::OP_R2;
		w[12:7] = rt;
		w[18:13] = ra;
		w[24:19] = rb;
		w[31:25] = fn;
		w[36:34] = pred;
		return w;
	endfunction

	// Immediate format with the predicate in bits 37 to 35 above the immediate
	function automatic decodePkg::instruction_t encImm(input logic [6:0] op, input logic [2:0] pred,
		input decodePkg::regspec_t rt, input decodePkg::regspec_t ra, input logic [15:0] val);
		decodePkg::instruction_t w;
		w = '0;
		w[6:0] = op;
		w[12:7] = rt;
		w[18:13] = ra;
		w[34:19] = val;
		w[37:35] = pred;
		return w;
	endfunction

	task automatic addEntry(input string name, input decodePkg::instruction_t w,
		input decodePkg::regspec_t rp, input decodePkg::regspec_t rt,
		input decodePkg::regspec_t ra, input decodePkg::regspec_t rb, input logic [31:0] im,
		input decodePkg::instrClass_t c);
		tName.push_back(name);
		tInstr.push_back(w);
		tRp.push_back(rp);
		tRt.push_back(rt);
		tRa.push_back(ra);
		tRb.push_back(rb);
		tImm.push_back(im);
		tCls.push_back(c);
	endtask

	// Formats with an immediate have Rt, Ra and no Rb
	task automatic addImmForm(input string name, input logic [6:0] op, input logic [2:0] pred,
		input decodePkg::regspec_t rt, input decodePkg::regspec_t ra, input logic [15:0] val,
		input decodePkg::instrClass_t c);
		addEntry(name, encImm(op, pred, rt, ra, val), decodePkg::predBase + 6'(pred), rt, ra,
			6'd63, {{16{val[15]}}, val}, c);
	endtask

	// ==============================
	// Stimulus table
	// ==============================

	task automatic buildTable();
		decodePkg::func_t fn;
		decodePkg::opcode_t immOps[11];
		decodePkg::opcode_t loadOps[8];
		decodePkg::instruction_t w;
		immOps = '{decodePkg::OP_ADDI, decodePkg::OP_SUBFI, decodePkg::OP_CMPI, decodePkg::OP_MULI,
			decodePkg::OP_DIVI, decodePkg::OP_SLTI, decodePkg::OP_MULUI, decodePkg::OP_DIVUI,
			decodePkg::OP_ANDI, decodePkg::OP_ORI, decodePkg::OP_EORI};
		loadOps = '{decodePkg::OP_LDB, decodePkg::OP_LDBU, decodePkg::OP_LDW, decodePkg::OP_LDWU,
			decodePkg::OP_LDT, decodePkg::OP_LDTU, decodePkg::OP_LDO, decodePkg::OP_LDX};
		// Every R2 function while the predicate field walks through all eight values
		fn = fn.first();
		for (int i = 0; i < fn.num(); i++)
		begin
			addEntry($sformatf("r2 %s", fn.name()),
				encR2(fn, 3'(i), 6'(i), 6'(i + 1), 6'(i + 2)),
				6'(32 + i % 8), 6'(i), 6'(i + 1), 6'(i + 2), 32'd0, decodePkg::CLS_ALU);
			fn = fn.next();
		end
		// Undefined functions are illegal and name no register
		addEntry("r2 fn 0", encR2(7'd0, 3'd2, 6'd7, 6'd8, 6'd9), 6'd63, 6'd63, 6'd63, 6'd63,
			32'd0, decodePkg::CLS_NONE);
		addEntry("r2 fn 22", encR2(7'd22, 3'd5, 6'd1, 6'd2, 6'd3), 6'd63, 6'd63, 6'd63, 6'd63,
			32'd0, decodePkg::CLS_NONE);
		for (int i = 0; i < 11; i++)
			addImmForm($sformatf("imm %s", immOps[i].name()), immOps[i], 3'(i), 6'(i + 1),
				6'(30 - i), 16'(nextRand() >> 7), decodePkg::CLS_ALU);
		for (int i = 0; i < 8; i++)
			addImmForm($sformatf("load %s", loadOps[i].name()), loadOps[i], 3'(7 - i), 6'(i + 12),
				6'(i + 20), 16'(nextRand() >> 9), decodePkg::CLS_LOAD);
		// JSR keeps Rt as its link register
		addImmForm("jsr", decodePkg::OP_JSR, 3'd7, 6'd1, 6'd2, 16'h0040, decodePkg::CLS_BRANCH);
		addEntry("rtd", encImm(decodePkg::OP_RTD, 3'd0, 6'd9, 6'd10, 16'hfff8), 6'd32, 6'd63,
			6'd63, 6'd63, 32'hfffffff8, decodePkg::CLS_BRANCH);
		// Bit 37 set so that the wrong predicate position would read 39
		w = '0;
		w[6:0] = decodePkg::OP_MOV;
		w[12:7] = 6'd3;
		w[18:13] = 6'd4;
		// MOV ignores the Rb bits, which also sit under the immediate field
		w[24:19] = 6'd21;
		w[37:34] = 4'b1110;
		addEntry("mov", w, 6'd38, 6'd3, 6'd4, 6'd63, 32'd0, decodePkg::CLS_MOVE);
		addEntry("nop", encImm(decodePkg::OP_NOP, 3'd5, 6'd1, 6'd2, 16'h1234), 6'd63, 6'd63,
			6'd63, 6'd63, 32'd0, decodePkg::CLS_NONE);
		addEntry("opcode 50", encImm(7'd50, 3'd3, 6'd4, 6'd5, 16'h8888), 6'd63, 6'd63, 6'd63,
			6'd63, 32'd0, decodePkg::CLS_NONE);
	endtask

	// ==============================
	// Handshake drivers
	// ==============================

	task automatic waitLevel(ref logic sig, input logic level, input string what);
		int cnt;
		cnt = 0;
		while (sig !== level)
		begin
			@(posedge clk);
			#2;
			cnt++;
			if (cnt > waitLimit)
				failNow($sformatf("timeout: %s never happened", what));
		end
	endtask

	task automatic pushAll();
		for (int i = 0; i < tName.size(); i++)
		begin
			instr = tInstr[i];
			inReq = 1'b1;
			waitLevel(inAck, 1'b1, "fetch handshake, inAck rising");
			inReq = 1'b0;
			waitLevel(inAck, 1'b0, "fetch handshake, inAck falling");
		end
	endtask

	// Random hold of outAck lets the capture slot fill behind a full output slot
	task automatic collectAll();
		int delay;
		for (int i = 0; i < tName.size(); i++)
		begin
			waitLevel(outReq, 1'b1, "issue handshake, outReq rising");
			delay = int'((nextRand() >> 11) % 32'd9);
			repeat (delay)
			begin
				@(posedge clk);
				#2;
			end
			checkReg(tName[i], "Rp", tRp[i], Rp);
			checkReg(tName[i], "Rt", tRt[i], Rt);
			checkReg(tName[i], "Ra", tRa[i], Ra);
			checkReg(tName[i], "Rb", tRb[i], Rb);
			checkImm(tName[i], tImm[i], imm);
			checkClass(tName[i], tCls[i], cls);
			outAck = 1'b1;
			waitLevel(outReq, 1'b0, "issue handshake, outReq falling");
			outAck = 1'b0;
		end
	endtask

	initial
	begin
		rstN = 1'b0;
		inReq = 1'b0;
		instr = '0;
		outAck = 1'b0;
		lcgState = 32'he87d94fe;
		buildTable();
		repeat (16) @(posedge clk);
		#2;
		rstN = 1'b1;
		@(posedge clk);
		#2;
		if (inAck !== 1'b0 || outReq !== 1'b0)
			failNow("inAck or outReq was not low after reset");
		fork
			pushAll();
			collectAll();
		join
		// Any further request would be a duplicated result
		repeat (20)
		begin
			@(posedge clk);
			#2;
			if (outReq !== 1'b0)
				failNow("the stage issued more results than were fetched");
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

/* dv/decodeStage_props.sv */
// Handshake assertions for the decode stage
// Four-phase rules on both sides, output field stability, reset state
// Bound into every decodeStage instance

`timescale 1ns/10ps

module decodeStageProps
(
	input logic clk,
	input logic rstN,
	input logic inReq,
	input logic inAck,
	input logic outReq,
	input logic outAck,
	input decodePkg::regspec_t Rp,
	input decodePkg::regspec_t Rt,
	input decodePkg::regspec_t Ra,
	input decodePkg::regspec_t Rb,
	input logic [decodePkg::dataWidth-1:0] imm,
	input decodePkg::instrClass_t cls
);

	// ==============================
	// Issue side
	// ==============================

	// A new request waits until the previous ack has returned low
	outReqRise: assert property (@(posedge clk) disable iff (!rstN)
		$rose(outReq) |-> !$past(outAck))
	else
		$error("outReq rose while outAck was high");

	// The issue side may sample the fields at any time while req is up
	fieldsStable: assert property (@(posedge clk) disable iff (!rstN)
		outReq && $past(outReq) |-> $stable({Rp, Rt, Ra, Rb, imm, cls}))
	else
		$error("output fields changed while outReq was high");

	// ==============================
	// Fetch side and reset
	// ==============================

	inAckRise: assert property (@(posedge clk) disable iff (!rstN)
		$rose(inAck) |-> $past(inReq))
	else
		$error("inAck rose while inReq was low");

	resetState: assert property (@(posedge clk)
		!rstN |=> (!inAck && !outReq))
	else
		$error("inAck or outReq high in the cycle after reset");

endmodule

bind decodeStage decodeStageProps uProps
(
	.clk(clk),
	.rstN(rstN),
	.inReq(inReq),
	.inAck(inAck),
	.outReq(outReq),
	.outAck(outAck),
	.Rp(Rp),
	.Rt(Rt),
	.Ra(Ra),
	.Rb(Rb),
	.imm(imm),
	.cls(cls)
);

/* logic/decodeStage.sv */
// Decode stage top level
// Capture slot with the four-phase fetch handshake
// Combinational predicate, register and class decoders
// Output slot with the four-phase issue handshake

`timescale 1ns/10ps

module decodeStage
(
	input logic clk,
	input logic rstN,
	input logic inReq,
	input decodePkg::instruction_t instr,
	output logic inAck,
	output logic outReq,
	output decodePkg::regspec_t Rp,
	output decodePkg::regspec_t Rt,
	output decodePkg::regspec_t Ra,
	output decodePkg::regspec_t Rb,
	output logic [decodePkg::dataWidth-1:0] imm,
	output decodePkg::instrClass_t cls,
	input logic outAck
);

	decodePkg::slotState_t capState;
	decodePkg::slotState_t outState;
	decodePkg::instruction_t capInstr;
	logic capLoad;
	logic transfer;

	// Decoder results for the instruction held in the capture slot
	decodePkg::regspec_t decRp;
	decodePkg::regspec_t decRt;
	decodePkg::regspec_t decRa;
	decodePkg::regspec_t decRb;
	logic [decodePkg::dataWidth-1:0] decImm;
	decodePkg::instrClass_t decCls;

	// A new request is taken only once the previous one has fully retired
	assign capLoad = (capState == decodePkg::SLOT_EMPTY) && inReq && !inAck;
	assign transfer = (capState == decodePkg::SLOT_FULL) && (outState == decodePkg::SLOT_EMPTY);

	// ==============================
	// Capture slot
	// ==============================

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			capState <= decodePkg::SLOT_EMPTY;
			inAck <= 1'b0;
		end
		else
		begin
			// Ack rises with the capture and falls once req is seen low
			if (capLoad)
				inAck <= 1'b1;
			else if (inAck && !inReq)
				inAck <= 1'b0;
			case (capState)
				decodePkg::SLOT_EMPTY:
					if (capLoad)
						capState <= decodePkg::SLOT_FULL;
				decodePkg::SLOT_FULL:
					// The word may leave before the fetch side has dropped req
					if (transfer)
					begin
						if (inAck && inReq)
							capState <= decodePkg::SLOT_WAIT_ACK_LOW;
						else
							capState <= decodePkg::SLOT_EMPTY;
					end
				decodePkg::SLOT_WAIT_ACK_LOW:
					if (!inReq)
						capState <= decodePkg::SLOT_EMPTY;
				default:
					capState <= decodePkg::SLOT_EMPTY;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (capLoad)
			capInstr <= instr;
	end

	// ==============================
	// Decoders
	// ==============================

	decodeRp uRp
	(
		.instr(capInstr),
		.Rp(decRp)
	);

	decodeRegs uRegs
	(
		.instr(capInstr),
		.Rt(decRt),
		.Ra(decRa),
		.Rb(decRb),
		.imm(decImm)
	);

	decodeClass uClass
	(
		.instr(capInstr),
		.cls(decCls)
	);

	// ==============================
	// Output slot
	// ==============================

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			outState <= decodePkg::SLOT_EMPTY;
			outReq <= 1'b0;
		end
		else
		begin
			case (outState)
				decodePkg::SLOT_EMPTY:
					if (transfer)
					begin
						outState <= decodePkg::SLOT_FULL;
						outReq <= 1'b1;
					end
				// Req falls on the edge after the issue side acknowledges
				decodePkg::SLOT_FULL:
					if (outAck)
					begin
						outState <= decodePkg::SLOT_WAIT_ACK_LOW;
						outReq <= 1'b0;
					end
				// Slot is reusable only after ack has returned low
				decodePkg::SLOT_WAIT_ACK_LOW:
					if (!outAck)
						outState <= decodePkg::SLOT_EMPTY;
				default:
				begin
					outState <= decodePkg::SLOT_EMPTY;
					outReq <= 1'b0;
				end
			endcase
		end
	end

	// Fields stay put from the transfer until the next one
	always_ff @(posedge clk)
	begin
		if (transfer)
		begin
			Rp <= decRp;
			Rt <= decRt;
			Ra <= decRa;
			Rb <= decRb;
			imm <= decImm;
			cls <= decCls;
		end
	end

endmodule

/* logic/decodeClass.sv */
// Instruction class decoder
// Maps each opcode, and the function for R2, onto the unit that
// executes it: ALU, LOAD, BRANCH, MOVE or NONE

`timescale 1ns/10ps

module decodeClass
(
	input decodePkg::instruction_t instr,
	output decodePkg::instrClass_t cls
);

	logic [6:0] opcode;
	logic [6:0] func;

	assign opcode = instr[6:0];
	assign func = instr[31:25];

	// ==============================
	// Opcode to class map
	// ==============================

	always_comb
	begin
		case (opcode)
			// An R2 word with an undefined function goes nowhere
			decodePkg::OP_R2:
				if (decodePkg::isKnownFunc(func))
				begin
					cls = decodePkg::CLS_ALU;
				end
				else
				begin
					cls = decodePkg::CLS_NONE;
				end
			// Immediate arithmetic and logic share the ALU with R2
			decodePkg::OP_ADDI, decodePkg::OP_SUBFI, decodePkg::OP_CMPI,
			decodePkg::OP_MULI, decodePkg::OP_DIVI, decodePkg::OP_SLTI,
			decodePkg::OP_MULUI, decodePkg::OP_DIVUI,
			decodePkg::OP_ANDI, decodePkg::OP_ORI, decodePkg::OP_EORI:
				cls = decodePkg::CLS_ALU;
			decodePkg::OP_LDB, decodePkg::OP_LDBU, decodePkg::OP_LDW,
			decodePkg::OP_LDWU, decodePkg::OP_LDT, decodePkg::OP_LDTU,
			decodePkg::OP_LDO, decodePkg::OP_LDX:
				cls = decodePkg::CLS_LOAD;
			// Subroutine call and return both redirect the fetch unit
			decodePkg::OP_JSR, decodePkg::OP_RTD:
				cls = decodePkg::CLS_BRANCH;
			decodePkg::OP_MOV:
				cls = decodePkg::CLS_MOVE;
			// NOP and unlisted opcodes need no execution unit
			default:
				cls = decodePkg::CLS_NONE;
		endcase
	end

endmodule

/* logic/decodeRegs.sv */
// Target and source register specifier decoder
// Rt, Ra and Rb per opcode, noReg for fields the format lacks
// Sign extended immediate for the formats that carry one

`timescale 1ns/10ps

module decodeRegs
(
	input decodePkg::instruction_t instr,
	output decodePkg::regspec_t Rt,
	output decodePkg::regspec_t Ra,
	output decodePkg::regspec_t Rb,
	output logic [decodePkg::dataWidth-1:0] imm
);

	logic [6:0] opcode;
	logic [6:0] func;
	decodePkg::regspec_t fldRt;
	decodePkg::regspec_t fldRa;
	decodePkg::regspec_t fldRb;
	logic [decodePkg::immWidth-1:0] fldImm;
	logic [decodePkg::dataWidth-1:0] immSext;

	assign opcode = instr[6:0];
	assign func = instr[31:25];
	assign fldRt = instr[12:7];
	assign fldRa = instr[18:13];
	assign fldRb = instr[24:19];
	// The immediate overlaps Rb and the function field
	assign fldImm = instr[34:19];

	assign immSext = {{(decodePkg::dataWidth - decodePkg::immWidth){fldImm[decodePkg::immWidth-1]}},
		fldImm};

	// ==============================
	// Specifier and immediate select
	// ==============================

	always_comb
	begin
		// Illegal and unlisted encodings fall through with no registers
		Rt = decodePkg::noReg;
		Ra = decodePkg::noReg;
		Rb = decodePkg::noReg;
		imm = '0;
		case (opcode)
			decodePkg::OP_R2:
				// Only a defined function reads and writes registers
				if (decodePkg::isKnownFunc(func))
				begin
					Rt = fldRt;
					Ra = fldRa;
					Rb = fldRb;
				end
			decodePkg::OP_ADDI, decodePkg::OP_SUBFI, decodePkg::OP_CMPI,
			decodePkg::OP_MULI, decodePkg::OP_DIVI, decodePkg::OP_SLTI,
			decodePkg::OP_MULUI, decodePkg::OP_DIVUI,
			decodePkg::OP_ANDI, decodePkg::OP_ORI, decodePkg::OP_EORI,
			decodePkg::OP_LDB, decodePkg::OP_LDBU, decodePkg::OP_LDW,
			decodePkg::OP_LDWU, decodePkg::OP_LDT, decodePkg::OP_LDTU,
			decodePkg::OP_LDO, decodePkg::OP_LDX:
			begin
				Rt = fldRt;
				Ra = fldRa;
				imm = immSext;
			end
			decodePkg::OP_MOV:
			begin
				Rt = fldRt;
				Ra = fldRa;
			end
			// JSR writes the return address into Rt as its link register
			decodePkg::OP_JSR:
			begin
				Rt = fldRt;
				Ra = fldRa;
				imm = immSext;
			end
			// RTD has no register operands, only the stack adjustment
			decodePkg::OP_RTD:
				imm = immSext;
			default:
				imm = '0;
		endcase
	end

endmodule

/* logic/decodeRp.sv */
// Predicate register specifier decoder
// Picks the predicate field by instruction format and maps it onto
// the predicate register range, or gives noReg

`timescale 1ns/10ps

module decodeRp
(
	input decodePkg::instruction_t instr,
	output decodePkg::regspec_t Rp
);

	logic [6:0] opcode;
	logic [6:0] func;
	// Predicate register named by the R2 and MOV field position
	decodePkg::regspec_t predLow;
	// Predicate register named by the position used by the other formats
	decodePkg::regspec_t predHigh;

	assign opcode = instr[6:0];
	assign func = instr[31:25];

	// Both positions are three bits wide, so the sum stays in 32 to 39
	assign predLow = decodePkg::predBase + decodePkg::regspec_t'(instr[36:34]);
	assign predHigh = decodePkg::predBase + decodePkg::regspec_t'(instr[37:35]);

	// ==============================
	// Format dependent selection
	// ==============================

	always_comb
	begin
		case (opcode)
			decodePkg::OP_R2:
				// An undefined function is illegal and names no predicate
				case (decodePkg::isKnownFunc(func))
					1'b1:
						Rp = predLow;
					default:
						Rp = decodePkg::noReg;
				endcase
			decodePkg::OP_JSR, decodePkg::OP_RTD:
				Rp = predHigh;
			decodePkg::OP_ADDI, decodePkg::OP_SUBFI, decodePkg::OP_CMPI,
			decodePkg::OP_MULI, decodePkg::OP_DIVI, decodePkg::OP_SLTI,
			decodePkg::OP_MULUI, decodePkg::OP_DIVUI,
			decodePkg::OP_ANDI, decodePkg::OP_ORI, decodePkg::OP_EORI:
				Rp = predHigh;
			// MOV shares its field layout with the R2 format
			decodePkg::OP_MOV:
				Rp = predLow;
			decodePkg::OP_LDB, decodePkg::OP_LDBU, decodePkg::OP_LDW,
			decodePkg::OP_LDWU, decodePkg::OP_LDT, decodePkg::OP_LDTU,
			decodePkg::OP_LDO, decodePkg::OP_LDX:
				Rp = predHigh;
			default:
				Rp = decodePkg::noReg;
		endcase
	end

endmodule

/* logic/decodePkg.sv */
// Shared definitions for the instruction decode stage
// Widths, register specifier constants and the instruction word type
// Opcode, R2 function, instruction class and slot state enums
// R2 function check used by the decoders

package decodePkg;

	// ==============================
	// Widths and constants
	// ==============================

	localparam int instrWidth = 40;
	localparam int regWidth = 6;
	localparam int immWidth = 16;
	localparam int dataWidth = 32;

	// Raw instruction word, fields are sliced by position in each decoder
	// Opcode 6:0, Rt 12:7, Ra 18:13, Rb 24:19, R2 function 31:25
	// Predicate at 36:34 for R2 and MOV, at 37:35 for the other formats
	// Immediate at 34:19, bits 39:38 are reserved
	typedef logic [instrWidth-1:0] instruction_t;
	typedef logic [regWidth-1:0] regspec_t;

	// Specifiers 32 to 39 name the predicate registers
	localparam regspec_t predBase = 6'd32;
	// Marks a field that the instruction does not use
	localparam regspec_t noReg = 6'd63;

	// ==============================
	// Encodings
	// ==============================

	typedef enum logic [6:0]
	{
		OP_R2 = 7'd2,
		OP_ADDI = 7'd4,
		OP_SUBFI = 7'd5,
		OP_CMPI = 7'd6,
		OP_MULI = 7'd7,
		OP_DIVI = 7'd8,
		OP_ANDI = 7'd9,
		OP_ORI = 7'd10,
		OP_EORI = 7'd11,
		OP_MOV = 7'd12,
		OP_SLTI = 7'd13,
		OP_MULUI = 7'd14,
		OP_DIVUI = 7'd15,
		OP_JSR = 7'd66,
		OP_RTD = 7'd67,
		OP_LDB = 7'd80,
		OP_LDBU = 7'd81,
		OP_LDW = 7'd82,
		OP_LDWU = 7'd83,
		OP_LDT = 7'd84,
		OP_LDTU = 7'd85,
		OP_LDO = 7'd86,
		OP_LDX = 7'd87,
		OP_NOP = 7'd127
	} opcode_t;

	// Function field of the register to register format
	typedef enum logic [6:0]
	{
		FN_CMP = 7'd3, FN_ADD = 7'd4, FN_SUB = 7'd5, FN_MUL = 7'd6,
		FN_DIV = 7'd7, FN_AND = 7'd8, FN_OR = 7'd9, FN_EOR = 7'd10,
		FN_ANDC = 7'd11, FN_NAND = 7'd12, FN_NOR = 7'd13, FN_MULU = 7'd14,
		FN_DIVU = 7'd15, FN_ENOR = 7'd16, FN_ORC = 7'd17, FN_MULH = 7'd18,
		FN_MOD = 7'd19, FN_MULUH = 7'd20, FN_MODU = 7'd21, FN_SEQ = 7'd24,
		FN_SNE = 7'd25, FN_SLT = 7'd26, FN_SLE = 7'd27, FN_SLTU = 7'd28,
		FN_SLEU = 7'd29
	} func_t;

	// Tells the issue logic which unit takes the instruction
	typedef enum logic [2:0]
	{
		CLS_NONE = 3'd0,
		CLS_ALU = 3'd1,
		CLS_LOAD = 3'd2,
		CLS_BRANCH = 3'd3,
		CLS_MOVE = 3'd4
	} instrClass_t;

	// Sequence of one pipeline slot in the decode stage
	typedef enum logic [1:0]
	{
		SLOT_EMPTY = 2'd0,
		SLOT_FULL = 2'd1,
		SLOT_WAIT_ACK_LOW = 2'd2
	} slotState_t;

	// True when the R2 function field holds one of the defined functions
	function automatic logic isKnownFunc(input logic [6:0] fn);
		logic known;
		case (fn)
			FN_CMP, FN_ADD, FN_SUB, FN_MUL, FN_DIV, FN_AND, FN_OR, FN_EOR,
			FN_ANDC, FN_NAND, FN_NOR, FN_MULU, FN_DIVU, FN_ENOR, FN_ORC,
			FN_MULH, FN_MOD, FN_MULUH, FN_MODU, FN_SEQ, FN_SNE, FN_SLT,
			FN_SLE, FN_SLTU, FN_SLEU:
				known = 1'b1;
			default:
				known = 1'b0;
		endcase
		return known;
	endfunction

endpackage
